// File: display_macros.svh
`ifndef DISPLAY_MACROS_SVH
`define DISPLAY_MACROS_SVH

// Visible frame size in pixels
`define DISPLAY_WIDTH 640
`define DISPLAY_HEIGHT 400

// Pixels in one full frame
`define DISPLAY_PIXELS (`DISPLAY_WIDTH * `DISPLAY_HEIGHT)

// Simulation cycle limit
// Six frames of 256000 cycles plus fill time and margin
`define TIMEOUT_CYCLES 2000000

`endif

// File: display_pkg.sv
package display_pkg;

    // One 4-bit colour index per pixel
    typedef logic [3:0] pixel_t;

    // Column 0 to 639
    typedef logic [9:0] x_coord_t;

    // Row 0 to 399
    typedef logic [8:0] y_coord_t;

    // Linear pixel index, row * width + column
    // Bit 17 picks the lower RAM, bits 16:3 the word, bits 2:0 the lane
    typedef logic [17:0] pixel_address_t;

    // Word address inside one RAM block
    typedef logic [13:0] ram_address_t;

    // Eight pixels per word, lane 0 in the low nibble
    typedef logic [31:0] ram_word_t;

    // Which buffer is currently on screen
    typedef enum logic {
        buffer_a,
        buffer_b
    } buffer_select_t;

endpackage

// File: display_ram.sv
module display_ram (
    input logic clock_in,
    input logic write_enable,
    input display_pkg::ram_address_t write_address,
    input display_pkg::ram_word_t write_data,
    input display_pkg::ram_address_t read_address,
    output display_pkg::ram_word_t read_data
);

    import display_pkg::*;

    localparam int unsigned DEPTH = 2 ** $bits(ram_address_t);

    ram_word_t memory [DEPTH];

    // Blank frame at power up
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            memory[i] = '0;
        end
    end

    // Same-address access returns the old word
    always_ff @(posedge clock_in) begin
        if (write_enable) begin
            memory[write_address] <= write_data;
        end
        read_data <= memory[read_address];
    end

endmodule

// File: display_buffers.sv
module display_buffers (
    input logic clock_in,
    input logic reset_n_in,

    input logic pixel_write_strobe,
    input display_pkg::pixel_address_t pixel_write_address,
    input display_pkg::pixel_t pixel_write_data,

    input logic scan_strobe,
    input display_pkg::pixel_address_t scan_address,
    input logic scan_frame_start,

    input logic switch_strobe,

    output logic pixel_valid,
    output display_pkg::pixel_t pixel_data,
    output logic frame_start
);

    import display_pkg::*;

    // Registered front buffer and the one used for this cycle's read
    buffer_select_t front_buffer;
    buffer_select_t read_buffer;
    logic front_index;
    logic switch_pending;
    logic swap_now;

    // RAM arrays indexed [buffer][half], half 0 is top and 1 is bottom
    ram_address_t ram_read_address [2];
    ram_word_t ram_read_data [2][2];
    logic [1:0][1:0] ram_write_enable;

    // Read pipeline
    logic read_valid_q;
    logic read_frame_q;
    logic read_half_q;
    logic [2:0] read_lane_q;
    ram_word_t front_word;

    // Pending read-modify-write
    logic write_pending;
    logic write_half;
    logic [2:0] write_lane;
    ram_address_t write_address;
    pixel_t write_data;
    ram_word_t back_word;
    ram_word_t merged_word;

    // Swap lands on the very cycle that issues address 0
    assign swap_now = switch_pending && scan_strobe && scan_frame_start;
    assign read_buffer = swap_now ? ((front_buffer == buffer_a) ? buffer_b : buffer_a)
                                  : front_buffer;

    // front_buffer one cycle later matches the buffer that was read,
    // so it can steer the returned data directly
    assign front_index = (front_buffer == buffer_b);

    always_comb begin
        if (read_buffer == buffer_a) begin
            ram_read_address[0] = scan_address[16:3];
            ram_read_address[1] = pixel_write_address[16:3];
        end else begin
            ram_read_address[0] = pixel_write_address[16:3];
            ram_read_address[1] = scan_address[16:3];
        end
    end

    assign front_word = ram_read_data[front_index][read_half_q];
    assign back_word = ram_read_data[!front_index][write_half];

    // Replace one nibble in the word fetched during the strobe cycle
    always_comb begin
        merged_word = back_word;
        merged_word[{write_lane, 2'b00} +: 4] = write_data;
    end

    // Only the selected half of the back buffer is written
    always_comb begin
        ram_write_enable = '0;
        if (write_pending) begin
            ram_write_enable[!front_index][write_half] = 1'b1;
        end
    end

    display_ram buffer_a_top (
        .clock_in(clock_in),
        .write_enable(ram_write_enable[0][0]),
        .write_address(write_address),
        .write_data(merged_word),
        .read_address(ram_read_address[0]),
        .read_data(ram_read_data[0][0])
    );

    display_ram buffer_a_bottom (
        .clock_in(clock_in),
        .write_enable(ram_write_enable[0][1]),
        .write_address(write_address),
        .write_data(merged_word),
        .read_address(ram_read_address[0]),
        .read_data(ram_read_data[0][1])
    );

    display_ram buffer_b_top (
        .clock_in(clock_in),
        .write_enable(ram_write_enable[1][0]),
        .write_address(write_address),
        .write_data(merged_word),
        .read_address(ram_read_address[1]),
        .read_data(ram_read_data[1][0])
    );

    display_ram buffer_b_bottom (
        .clock_in(clock_in),
        .write_enable(ram_write_enable[1][1]),
        .write_address(write_address),
        .write_data(merged_word),
        .read_address(ram_read_address[1]),
        .read_data(ram_read_data[1][1])
    );

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            front_buffer <= buffer_a;
            switch_pending <= 1'b0;
            read_valid_q <= 1'b0;
            read_frame_q <= 1'b0;
            pixel_valid <= 1'b0;
            frame_start <= 1'b0;
            write_pending <= 1'b0;
        end else begin
            front_buffer <= read_buffer;

            // A new request during the swap cycle waits for the next frame
            if (switch_strobe) begin
                switch_pending <= 1'b1;
            end else if (swap_now) begin
                switch_pending <= 1'b0;
            end

            read_valid_q <= scan_strobe;
            read_frame_q <= scan_strobe && scan_frame_start;
            pixel_valid <= read_valid_q;
            frame_start <= read_frame_q;

            write_pending <= pixel_write_strobe;
        end
    end

    always_ff @(posedge clock_in) begin
        read_half_q <= scan_address[17];
        read_lane_q <= scan_address[2:0];
        pixel_data <= front_word[{read_lane_q, 2'b00} +: 4];

        write_address <= pixel_write_address[16:3];
        write_half <= pixel_write_address[17];
        write_lane <= pixel_write_address[2:0];
        write_data <= pixel_write_data;
    end

endmodule

// File: rectangle_filler.sv
`include "display_macros.svh"

module rectangle_filler (
    input logic clock_in,
    input logic reset_n_in,

    input logic fill_strobe,
    input display_pkg::x_coord_t fill_x0,
    input display_pkg::y_coord_t fill_y0,
    input display_pkg::x_coord_t fill_x1,
    input display_pkg::y_coord_t fill_y1,
    input display_pkg::pixel_t fill_colour,
    output logic fill_busy,

    output logic pixel_write_strobe,
    output display_pkg::pixel_address_t pixel_write_address,
    output display_pkg::pixel_t pixel_write_data
);

    import display_pkg::*;

    logic phase;
    x_coord_t x0_q;
    x_coord_t x1_q;
    y_coord_t y1_q;
    x_coord_t cur_x;
    y_coord_t cur_y;
    pixel_t colour_q;
    pixel_address_t address_q;
    pixel_address_t row_step_q;

    // Every second busy cycle carries a write
    assign pixel_write_strobe = fill_busy && phase;
    assign pixel_write_address = address_q;
    assign pixel_write_data = colour_q;

    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            fill_busy <= 1'b0;
            phase <= 1'b0;
        end else if (!fill_busy) begin
            if (fill_strobe) begin
                fill_busy <= 1'b1;
                phase <= 1'b0;
            end
        end else begin
            phase <= !phase;
            if (phase && cur_x == x1_q && cur_y == y1_q) begin
                fill_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock_in) begin
        if (!fill_busy && fill_strobe) begin
            x0_q <= fill_x0;
            x1_q <= fill_x1;
            y1_q <= fill_y1;
            colour_q <= fill_colour;
            cur_x <= fill_x0;
            cur_y <= fill_y0;
            address_q <= pixel_address_t'(pixel_address_t'(fill_y0) *
                         pixel_address_t'(`DISPLAY_WIDTH)) + pixel_address_t'(fill_x0);
            // From the last column of a row to the first of the next
            row_step_q <= pixel_address_t'(`DISPLAY_WIDTH) -
                          pixel_address_t'(fill_x1 - fill_x0);
        end else if (fill_busy && phase) begin
            if (cur_x == x1_q) begin
                cur_x <= x0_q;
                cur_y <= cur_y + y_coord_t'(1);
                address_q <= address_q + row_step_q;
            end else begin
                cur_x <= cur_x + x_coord_t'(1);
                address_q <= address_q + pixel_address_t'(1);
            end
        end
    end

endmodule

// File: raster_scanner.sv
`include "display_macros.svh"

module raster_scanner (
    input logic clock_in,
    input logic reset_n_in,

    output logic scan_strobe,
    output display_pkg::pixel_address_t scan_address,
    output logic scan_frame_start
);

    import display_pkg::*;

    localparam pixel_address_t LAST_PIXEL = pixel_address_t'(`DISPLAY_PIXELS - 1);

    // Free running from the first cycle out of reset
    always_ff @(posedge clock_in) begin
        if (!reset_n_in) begin
            scan_strobe <= 1'b0;
            scan_address <= '0;
        end else begin
            scan_strobe <= 1'b1;
            if (scan_strobe) begin
                if (scan_address == LAST_PIXEL) begin
                    scan_address <= '0;
                end else begin
                    scan_address <= scan_address + pixel_address_t'(1);
                end
            end
        end
    end

    // Top left pixel marks a new frame
    assign scan_frame_start = scan_strobe && (scan_address == '0);

endmodule

// File: display_subsystem.sv
module display_subsystem (
    input logic clock_in,
    input logic reset_n_in,

    input logic fill_strobe,
    input display_pkg::x_coord_t fill_x0,
    input display_pkg::y_coord_t fill_y0,
    input display_pkg::x_coord_t fill_x1,
    input display_pkg::y_coord_t fill_y1,
    input display_pkg::pixel_t fill_colour,
    input logic switch_strobe,

    output logic fill_busy,
    output logic pixel_valid,
    output display_pkg::pixel_t pixel_data,
    output logic frame_start
);

    import display_pkg::*;

    logic pixel_write_strobe;
    pixel_address_t pixel_write_address;
    pixel_t pixel_write_data;

    logic scan_strobe;
    pixel_address_t scan_address;
    logic scan_frame_start;

    // Draws into the back buffer
    rectangle_filler filler (
        .clock_in(clock_in),
        .reset_n_in(reset_n_in),
        .fill_strobe(fill_strobe),
        .fill_x0(fill_x0),
        .fill_y0(fill_y0),
        .fill_x1(fill_x1),
        .fill_y1(fill_y1),
        .fill_colour(fill_colour),
        .fill_busy(fill_busy),
        .pixel_write_strobe(pixel_write_strobe),
        .pixel_write_address(pixel_write_address),
        .pixel_write_data(pixel_write_data)
    );

    raster_scanner scanner (
        .clock_in(clock_in),
        .reset_n_in(reset_n_in),
        .scan_strobe(scan_strobe),
        .scan_address(scan_address),
        .scan_frame_start(scan_frame_start)
    );

    display_buffers buffers (
        .clock_in(clock_in),
        .reset_n_in(reset_n_in),
        .pixel_write_strobe(pixel_write_strobe),
        .pixel_write_address(pixel_write_address),
        .pixel_write_data(pixel_write_data),
        .scan_strobe(scan_strobe),
        .scan_address(scan_address),
        .scan_frame_start(scan_frame_start),
        .switch_strobe(switch_strobe),
        .pixel_valid(pixel_valid),
        .pixel_data(pixel_data),
        .frame_start(frame_start)
    );

endmodule

// File: display_subsystem_props.sv
module display_subsystem_props (
    input logic clock_in,
    input logic reset_n_in,
    input logic pixel_write_strobe,
    input logic [1:0][1:0] ram_write_enable,
    input display_pkg::buffer_select_t read_buffer,
    input logic pixel_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    import display_pkg::*;

    int failure_count = 0;

    // Filler leaves an idle cycle between writes
    write_spacing: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        pixel_write_strobe |=> !pixel_write_strobe)
        else begin
            $error("pixel write strobes in two consecutive cycles");
            failure_count++;
        end

    // At most one RAM written, and never the buffer scanned this cycle
    back_buffer_write: assert property (@(posedge clock_in) disable iff (!reset_n_in)
        $onehot0(ram_write_enable) && (ram_write_enable[read_buffer == buffer_b] == 2'b00))
        else begin
            $error("RAM write enable outside the back buffer or more than one");
            failure_count++;
        end

    reset_quiet: assert property (@(posedge clock_in) !reset_n_in |=> !pixel_valid)
        else begin
            $error("pixel_valid high during reset");
            failure_count++;
        end

endmodule

bind display_buffers display_subsystem_props props (
    .clock_in(clock_in),
    .reset_n_in(reset_n_in),
    .pixel_write_strobe(pixel_write_strobe),
    .ram_write_enable(ram_write_enable),
    .read_buffer(read_buffer),
    .pixel_valid(pixel_valid)
);

// File: display_subsystem_tb.sv
`include "display_macros.svh"

module display_subsystem_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import display_pkg::*;

    localparam int PIXELS = `DISPLAY_PIXELS;
    localparam int WIDTH = `DISPLAY_WIDTH;

    logic clock_in = 1'b0;
    logic reset_n_in;
    logic fill_strobe;
    x_coord_t fill_x0;
    y_coord_t fill_y0;
    x_coord_t fill_x1;
    y_coord_t fill_y1;
    pixel_t fill_colour;
    logic switch_strobe;
    logic fill_busy;
    logic pixel_valid;
    pixel_t pixel_data;
    logic frame_start;

    // Image of both buffers, index 0 is buffer_a
    pixel_t model_pixels [2][PIXELS];
    logic model_front;
    logic model_switch_pending;
    int beat_index;
    int frames_seen;
    int cycle_count = 0;
    logic [31:0] lfsr_state;

    display_subsystem uut (
        .clock_in(clock_in),
        .reset_n_in(reset_n_in),
        .fill_strobe(fill_strobe),
        .fill_x0(fill_x0),
        .fill_y0(fill_y0),
        .fill_x1(fill_x1),
        .fill_y1(fill_y1),
        .fill_colour(fill_colour),
        .switch_strobe(switch_strobe),
        .fill_busy(fill_busy),
        .pixel_valid(pixel_valid),
        .pixel_data(pixel_data),
        .frame_start(frame_start)
    );

    always #2 clock_in = ~clock_in;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] value;
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            value = {value[30:0], feedback};
        end
        return value;
    endfunction

    function automatic pixel_t expected_pixel(input logic buffer_index, input int index);
        return model_pixels[buffer_index][index];
    endfunction

    task automatic fill_rectangle(input x_coord_t x0, input y_coord_t y0, input x_coord_t x1,
                                  input y_coord_t y1, input pixel_t colour,
                                  input bit inject_ignored);
        int pixel_count;
        int busy_cycles;
        logic back;
        back = !model_front;
        pixel_count = (int'(x1) - int'(x0) + 1) * (int'(y1) - int'(y0) + 1);
        for (int y = int'(y0); y <= int'(y1); y++) begin
            for (int x = int'(x0); x <= int'(x1); x++) begin
                model_pixels[back][y * WIDTH + x] = colour;
            end
        end
        fill_x0 = x0;
        fill_y0 = y0;
        fill_x1 = x1;
        fill_y1 = y1;
        fill_colour = colour;
        fill_strobe = 1'b1;
        @(negedge clock_in);
        fill_strobe = 1'b0;
        busy_cycles = 0;
        while (fill_busy) begin
            busy_cycles++;
            // A second command while busy must be dropped
            if (inject_ignored && busy_cycles == 3) begin
                fill_x0 = '0;
                fill_y0 = '0;
                fill_x1 = 10'd99;
                fill_y1 = 9'd99;
                fill_colour = 4'hf;
                fill_strobe = 1'b1;
            end
            @(negedge clock_in);
            fill_strobe = 1'b0;
        end
        assert (busy_cycles == 2 * pixel_count)
            else abort_run($sformatf("mismatch at %0t ns: fill_busy high %0d cycles, expected %0d",
                                     $time, busy_cycles, 2 * pixel_count));
    endtask

    task automatic random_fill();
        int width;
        int height;
        x_coord_t x0;
        y_coord_t y0;
        pixel_t colour;
        width = int'(take_bits(6)) + 1;
        height = int'(take_bits(5)) + 1;
        x0 = x_coord_t'(int'(take_bits(10)) % (WIDTH - width + 1));
        y0 = y_coord_t'(int'(take_bits(9)) % (`DISPLAY_HEIGHT - height + 1));
        colour = pixel_t'(take_bits(4));
        fill_rectangle(x0, y0, x_coord_t'(int'(x0) + width - 1),
                       y_coord_t'(int'(y0) + height - 1), colour, 1'b0);
    endtask

    // Strobe well away from the frame boundary
    task automatic issue_switch();
        while (beat_index < 1000 || beat_index > PIXELS - 1000) begin
            @(negedge clock_in);
        end
        switch_strobe = 1'b1;
        @(negedge clock_in);
        switch_strobe = 1'b0;
    endtask

    task automatic wait_for_frame(input int count);
        wait (frames_seen >= count);
        @(negedge clock_in);
    endtask

    // Output stream against the model front buffer
    always @(posedge clock_in) begin
        if (!reset_n_in) begin
            model_front = 1'b0;
            model_switch_pending = 1'b0;
            beat_index = 0;
            frames_seen = 0;
        end else begin
            if (switch_strobe) begin
                model_switch_pending = 1'b1;
            end
            if (pixel_valid && frame_start) begin
                assert (frames_seen == 0 || beat_index == PIXELS - 1)
                    else abort_run("frame_start arrived before the end of the frame");
                beat_index = 0;
                frames_seen++;
                if (model_switch_pending) begin
                    model_front = !model_front;
                    model_switch_pending = 1'b0;
                end
            end else if (pixel_valid) begin
                assert (frames_seen > 0 && beat_index < PIXELS - 1)
                    else abort_run("pixel_valid beat outside a frame");
                beat_index++;
            end else begin
                assert (frames_seen == 0)
                    else abort_run("pixel_valid dropped in the middle of the pixel stream");
            end
            if (pixel_valid) begin
                assert (pixel_data == expected_pixel(model_front, beat_index))
                    else abort_run($sformatf("mismatch at %0t ns: buffer %0d pixel %0d exp %h got %h",
                                             $time, model_front, beat_index,
                                             expected_pixel(model_front, beat_index), pixel_data));
            end
        end
    end

    always @(posedge clock_in) begin
        cycle_count++;
        if (cycle_count >= `TIMEOUT_CYCLES) begin
            abort_run("timeout, the run did not finish within the cycle limit");
        end
        assert (uut.buffers.props.failure_count == 0)
            else abort_run("an assertion bound into display_buffers failed");
    end

    initial begin
        lfsr_state = 32'h59d1a45c;
        reset_n_in = 1'b0;
        fill_strobe = 1'b0;
        fill_x0 = '0;
        fill_y0 = '0;
        fill_x1 = '0;
        fill_y1 = '0;
        fill_colour = '0;
        switch_strobe = 1'b0;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < PIXELS; i++) begin
                model_pixels[b][i] = '0;
            end
        end
        repeat (4) @(posedge clock_in);
        @(negedge clock_in);
        reset_n_in = 1'b1;
        @(negedge clock_in);
        assert (!fill_busy && !pixel_valid)
            else abort_run("fill_busy or pixel_valid high right after reset");

        // Buffer_a on screen, all drawing goes to buffer_b
        repeat (8) random_fill();
        // Shared words in the upper RAM
        fill_rectangle(10'd10, 9'd5, 10'd10, 9'd8, 4'h7, 1'b0);
        fill_rectangle(10'd11, 9'd5, 10'd11, 9'd8, 4'h9, 1'b0);
        fill_rectangle(10'd8, 9'd6, 10'd13, 9'd6, 4'h3, 1'b0);
        // Lower RAM, and a run across pixel 131072
        fill_rectangle(10'd633, 9'd300, 10'd633, 9'd302, 4'h5, 1'b0);
        fill_rectangle(10'd630, 9'd301, 10'd639, 9'd301, 4'hc, 1'b0);
        fill_rectangle(10'd508, 9'd204, 10'd515, 9'd204, 4'ha, 1'b0);
        fill_rectangle(10'd200, 9'd40, 10'd230, 9'd49, 4'h6, 1'b1);
        issue_switch();

        // Frame 1 shows buffer_b, buffer_a becomes the back buffer
        wait_for_frame(2);
        repeat (6) random_fill();
        fill_rectangle(10'd12, 9'd7, 10'd12, 9'd7, 4'hd, 1'b0);
        fill_rectangle(10'd300, 9'd350, 10'd305, 9'd352, 4'h2, 1'b0);
        issue_switch();

        // Frame 2 shows buffer_a, then back to buffer_b
        wait_for_frame(3);
        issue_switch();
        wait_for_frame(5);

        if (uut.buffers.props.failure_count == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Regression failed");
            $fatal(1, "bound assertions reported failures");
        end
    end

endmodule

// File: display_subsystem.f
+incdir+.
display_pkg.sv
display_ram.sv
display_buffers.sv
rectangle_filler.sv
raster_scanner.sv
display_subsystem.sv
display_subsystem_props.sv
display_subsystem_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILE_LIST ?= display_subsystem.f
TOP ?= display_subsystem_tb
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert --timescale 1ns/1ps
SIM_FLAGS ?= +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR FILE_LIST TOP BUILD_DIR VERILATOR_FLAGS SIM_FLAGS"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS)

clean:
	rm -rf $(BUILD_DIR)
